/* tb.f */
+incdir+rtl
rtl/routerPkg.sv
rtl/inputPort.sv
rtl/portArbiter.sv
rtl/outputPort.sv
rtl/meshRouter.sv
tests/router_sva.sv
tests/routerTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= routerTb
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides the result, a stopped run has no pass line
run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/routerTb.sv */
`timescale 1ns/100ps
`include "router_settings.svh"

module routerTb
  import routerPkg::*;
();

  localparam int RouterX = 2;
  localparam int RouterY = 2;
  localparam int MaxPkts = 256;

  logic clk;
  logic rst;
  logic [4:0] inValid;
  flitT [4:0] inFlit;
  logic [4:0] creditIn;
  logic [4:0] creditOut;
  logic [4:0] outValid;
  flitT [4:0] outFlit;

  int unsigned seed;
  int errors;
  int timeouts;
  logic stall;
  flitT sendQ [5][$];
  int upCred [5];
  int sentIn [5];
  int credBack [5];
  int pend [5];
  int curPkt [5];
  int nextIdx [5];
  int remain [5];
  int pktDest [MaxPkts];
  int pktLen [MaxPkts];
  int pktGot [MaxPkts];
  int numPkts;
  int injected;
  int delivered;
  int rotExp [$];

  meshRouter #(
    .routerX(RouterX),
    .routerY(RouterY)
  ) UUT (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inFlit(inFlit),
    .creditIn(creditIn),
    .creditOut(creditOut),
    .outValid(outValid),
    .outFlit(outFlit)
  );

  bind meshRouter routerSva sva (
    .clk(clk),
    .rst(rst),
    .outValid(outValid),
    .creditIn(creditIn),
    .creditOut(creditOut),
    .grant(grant),
    .sent(sent),
    .notEmpty(notEmpty)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int unsigned nextRand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 16;
  endfunction

  // XY order, X first
  function automatic int xyPort(input int dx, input int dy);
    if (dx > RouterX)
      return int'(portEast);
    if (dx < RouterX)
      return int'(portWest);
    if (dy > RouterY)
      return int'(portNorth);
    if (dy < RouterY)
      return int'(portSouth);
    return int'(portLocal);
  endfunction

  task automatic check(input bit ok, input string msg);
    assert (ok)
    else
    begin
      errors++;
      $display("FAILED at %0t ns: %s", $time, msg);
    end
  endtask

  task automatic sendPacket(input int src, input int dx, input int dy, input int len);
    int id;
    flitT f;
    id = numPkts;
    numPkts++;
    pktDest[id] = xyPort(dx, dy);
    pktLen[id] = len;
    for (int k = 0; k < len; k++)
    begin
      // packet id and flit index ride in the low payload bits
      if (k == 0)
        f = {1'b1, coordT'(dx), coordT'(dy), lenT'(len), 1'b0, 8'(id), 8'(k)};
      else
        f = {16'h0, 8'(id), 8'(k)};
      sendQ[src].push_back(f);
    end
    injected += len;
  endtask

  task automatic checkFlit(input int p, input flitT f);
    int id;
    int idx;
    id = f[15:8];
    idx = f[7:0];
    if (f[31])
    begin
      check(remain[p] == 0, $sformatf("port %0d head of packet %0d cuts into packet %0d",
        p, id, curPkt[p]));
      check(pktDest[id] == p, $sformatf("packet %0d left at port %0d, expected port %0d",
        id, p, pktDest[id]));
      check(idx == 0 && f[24:17] == pktLen[id], $sformatf("packet %0d head is malformed", id));
      if (p == int'(portEast) && rotExp.size() > 0)
      begin
        check(id == rotExp[0], $sformatf("east granted packet %0d, expected packet %0d",
          id, rotExp[0]));
        rotExp.delete(0);
      end
      curPkt[p] = id;
      nextIdx[p] = 1;
      remain[p] = pktLen[id] - 1;
    end
    else
    begin
      check(remain[p] > 0 && id == curPkt[p] && idx == nextIdx[p],
        $sformatf("port %0d body flit %0d.%0d, expected %0d.%0d",
        p, id, idx, curPkt[p], nextIdx[p]));
      nextIdx[p]++;
      if (remain[p] > 0)
        remain[p]--;
    end
    pktGot[id]++;
    delivered++;
  endtask

  // upstream senders, downstream sinks and the output monitor
  always @(negedge clk)
  begin
    if (!rst)
    begin
      for (int p = 0; p < 5; p++)
      begin
        if (outValid[p])
        begin
          checkFlit(p, outFlit[p]);
          pend[p]++;
        end
        if (creditOut[p])
        begin
          upCred[p]++;
          credBack[p]++;
        end
        if (sendQ[p].size() > 0 && upCred[p] > 0)
        begin
          inValid[p] = 1'b1;
          inFlit[p] = sendQ[p].pop_front();
          upCred[p]--;
          sentIn[p]++;
        end
        else
        begin
          inValid[p] = 1'b0;
        end
        // random credit return delay, none while stalled
        if (!stall && pend[p] > 0 && (nextRand() % 2) == 1)
        begin
          creditIn[p] = 1'b1;
          pend[p]--;
        end
        else
        begin
          creditIn[p] = 1'b0;
        end
      end
    end
  end

  function automatic bit drained();
    bit idle;
    idle = (delivered == injected);
    for (int p = 0; p < 5; p++)
    begin
      if (sendQ[p].size() != 0 || pend[p] != 0)
        idle = 1'b0;
    end
    return idle;
  endfunction

  task automatic finishRun();
    int svaFails;
    svaFails = UUT.sva.failCount;
    $display("checks done: %0d errors, %0d timeouts, %0d assertion failures",
      errors, timeouts, svaFails);
    if (errors == 0 && timeouts == 0 && svaFails == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic waitDrain(input int limit);
    int n;
    n = 0;
    while (!drained() && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    if (!drained())
    begin
      timeouts++;
      $display("timeout: router still holds flits after %0d cycles", limit);
    end
  endtask

  task automatic randomPackets(input int count, input int maxGap);
    int src;
    int dx;
    int dy;
    int len;
    int gap;
    for (int n = 0; n < count; n++)
    begin
      src = nextRand() % 5;
      dx = nextRand() % 5;
      dy = nextRand() % 5;
      len = 1 + nextRand() % 6;
      gap = nextRand() % (maxGap + 1);
      sendPacket(src, dx, dy, len);
      repeat (gap) @(posedge clk);
    end
  endtask

  initial
  begin
    int srcId [5];
    int p;
    seed = 29;
    errors = 0;
    timeouts = 0;
    numPkts = 0;
    injected = 0;
    delivered = 0;
    stall = 1'b0;
    rst = 1'b1;
    inValid = '0;
    inFlit = '0;
    creditIn = '0;
    for (int i = 0; i < 5; i++)
    begin
      upCred[i] = `FIFO_DEPTH;
      sentIn[i] = 0;
      credBack[i] = 0;
      pend[i] = 0;
      curPkt[i] = 0;
      nextIdx[i] = 0;
      remain[i] = 0;
    end
    for (int i = 0; i < MaxPkts; i++)
    begin
      pktDest[i] = -1;
      pktLen[i] = 0;
      pktGot[i] = 0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check(outValid == '0 && creditOut == '0, "outputs active right after reset");

    // one West packet moves the East rotation past West
    @(posedge clk);
    sendPacket(int'(portWest), 4, 2, 2);
    waitDrain(200);

    // four heads reach the East arbiter in the same cycle
    @(posedge clk);
    for (int s = 0; s < 5; s++)
    begin
      srcId[s] = numPkts;
      if (s != int'(portEast))
        sendPacket(s, 4, 2, 3);
    end
    for (int k = 1; k <= 5; k++)
    begin
      p = (int'(portWest) + k) % 5;
      if (p != int'(portEast))
        rotExp.push_back(srcId[p]);
    end
    waitDrain(200);

    randomPackets(40, 3);
    waitDrain(2000);

    // downstream holds every credit for a while
    stall = 1'b1;
    randomPackets(12, 0);
    repeat (60) @(posedge clk);
    stall = 1'b0;
    waitDrain(2000);

    check(rotExp.size() == 0, "rotation burst not fully seen on East");
    for (int i = 0; i < numPkts; i++)
    begin
      check(pktGot[i] == pktLen[i], $sformatf("packet %0d delivered %0d of %0d flits",
        i, pktGot[i], pktLen[i]));
    end
    for (int i = 0; i < 5; i++)
    begin
      check(credBack[i] == sentIn[i], $sformatf("input %0d returned %0d credits for %0d flits",
        i, credBack[i], sentIn[i]));
    end
    finishRun();
  end

endmodule

/* tests/router_sva.sv */
`timescale 1ns/100ps
`include "router_settings.svh"

module routerSva
(
  input logic            clk,
  input logic            rst,
  input logic [4:0]      outValid,
  input logic [4:0]      creditIn,
  input logic [4:0]      creditOut,
  input logic [4:0][4:0] grant,
  input logic [4:0][4:0] sent,
  input logic [4:0]      notEmpty
);

  int unsigned failCount = 0;
  // flits sent per output and not yet credited back
  int inFlight [5];

  always_ff @(posedge clk)
  begin
    for (int o = 0; o < 5; o++)
    begin
      if (rst)
        inFlight[o] <= 0;
      else
        inFlight[o] <= inFlight[o] + int'(outValid[o]) - int'(creditIn[o]);
    end
  end

  resetQuiet: assert property (@(posedge clk)
    rst |=> (outValid == '0 && creditOut == '0 && grant == '0))
  else
  begin
    failCount++;
    $error("outputs, credits or grants active after reset");
  end

  for (genvar o = 0; o < 5; o++)
  begin : gOut
    creditBound: assert property (@(posedge clk) disable iff (rst)
      inFlight[o] <= `FIFO_DEPTH)
    else
    begin
      failCount++;
      $error("output %0d has more flits in flight than credits", o);
    end

    // the flit on outValid already holds a credit
    sendsOnCredit: assert property (@(posedge clk) disable iff (rst)
      ((grant[o] & notEmpty) != '0 && inFlight[o] + int'(outValid[o]) < `FIFO_DEPTH)
        |-> sent[o] != '0)
    else
    begin
      failCount++;
      $error("output %0d held a granted flit while credits remained", o);
    end
  end

  for (genvar i = 0; i < 5; i++)
  begin : gIn
    logic [4:0] grantedBy;

    for (genvar o = 0; o < 5; o++)
    begin : gBit
      assign grantedBy[o] = grant[o][i];
    end

    // an input streams one packet to one output at a time
    singleOutput: assert property (@(posedge clk) disable iff (rst) $onehot0(grantedBy))
    else
    begin
      failCount++;
      $error("input %0d is granted by more than one output", i);
    end
  end

endmodule

/* rtl/meshRouter.sv */
`timescale 1ns/100ps

module meshRouter
  import routerPkg::*;
#(
  parameter int routerX = 0,
  parameter int routerY = 0
)
(
  input  logic       clk,
  input  logic       rst,
  input  logic [4:0] inValid,
  input  flitT [4:0] inFlit,
  input  logic [4:0] creditIn,
  output logic [4:0] creditOut,
  output logic [4:0] outValid,
  output flitT [4:0] outFlit
);

  // first index is the driving side
  logic [4:0][4:0] reqVec;
  logic [4:0][4:0] reqByOut;
  logic [4:0][4:0] grant;
  logic [4:0][4:0] sent;
  logic [4:0][4:0] sentByIn;
  flitT [4:0] frontFlit;
  lenT [4:0] frontLen;
  logic [4:0] notEmpty;

  for (genvar i = 0; i < 5; i++)
  begin : gXpose
    for (genvar o = 0; o < 5; o++)
    begin : gBit
      assign reqByOut[o][i] = reqVec[i][o];
      assign sentByIn[i][o] = sent[o][i];
    end
  end

  for (genvar p = 0; p < 5; p++)
  begin : gPort
    inputPort #(
      .routerX(routerX),
      .routerY(routerY)
    ) inPort (
      .clk(clk),
      .rst(rst),
      .inValid(inValid[p]),
      .inFlit(inFlit[p]),
      .sent(sentByIn[p]),
      .creditOut(creditOut[p]),
      .reqVec(reqVec[p]),
      .frontFlit(frontFlit[p]),
      .frontLen(frontLen[p]),
      .notEmpty(notEmpty[p])
    );

    portArbiter arb (
      .clk(clk),
      .rst(rst),
      .req(reqByOut[p]),
      .frontLen(frontLen),
      .sent(sent[p]),
      .grant(grant[p])
    );

    outputPort outPort (
      .clk(clk),
      .rst(rst),
      .grant(grant[p]),
      .frontFlit(frontFlit),
      .notEmpty(notEmpty),
      .creditIn(creditIn[p]),
      .sent(sent[p]),
      .outValid(outValid[p]),
      .outFlit(outFlit[p])
    );
  end

endmodule

/* rtl/outputPort.sv */
`timescale 1ns/100ps
`include "router_settings.svh"

module outputPort
  import routerPkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic    [4:0] grant,
  input  flitT    [4:0] frontFlit,
  input  logic    [4:0] notEmpty,
  input  logic          creditIn,
  output logic    [4:0] sent,
  output logic          outValid,
  output flitT          outFlit
);

  flitT selFlit;
  logic avail;
  logic fire;
  creditT credits;

  // grant is one-hot, so an OR mux is enough
  always_comb
  begin
    selFlit = '0;
    avail = 1'b0;
    for (int i = 0; i < 5; i++)
    begin
      if (grant[i])
      begin
        selFlit = selFlit | frontFlit[i];
        avail = avail | notEmpty[i];
      end
    end
  end

  assign fire = avail && (credits != '0);
  assign sent = fire ? grant : 5'b0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      credits <= creditT'(`FIFO_DEPTH);
      outValid <= 1'b0;
    end
    else
    begin
      outValid <= fire;
      // send and return may land in the same cycle
      case ({fire, creditIn})
        2'b10:
          credits <= credits - 1'b1;
        2'b01:
          credits <= credits + 1'b1;
        default:
          credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (fire)
    begin
      outFlit <= selFlit;
    end
  end

endmodule

/* rtl/portArbiter.sv */
`timescale 1ns/100ps

module portArbiter
  import routerPkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic    [4:0] req,
  input  lenT     [4:0] frontLen,
  input  logic    [4:0] sent,
  output logic    [4:0] grant
);

  arbStateT state;
  portT ptr;
  portT owner;
  portT winner;
  lenT count;
  logic found;

  function automatic portT nextPort(input portT p);
    if (p == portSouth)
      return portLocal;
    return portT'(p + 3'd1);
  endfunction

  // first requester in rotating order starting at ptr
  always_comb
  begin
    int unsigned idx;
    found = 1'b0;
    winner = ptr;
    for (int k = 0; k < 5; k++)
    begin
      idx = (int'(ptr) + k) % 5;
      if (!found && req[idx])
      begin
        found = 1'b1;
        winner = portT'(idx);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= arbIdle;
      ptr <= portLocal;
      owner <= portLocal;
      count <= '0;
    end
    else
    begin
      case (state)
        arbIdle:
        begin
          if (found)
          begin
            state <= arbBusy;
            owner <= winner;
            // winner's front is its head flit here
            count <= frontLen[winner];
          end
        end
        arbBusy:
        begin
          if (sent[owner])
          begin
            count <= count - 1'b1;
            // a zero length head is treated as a single flit
            if (count <= lenT'(1))
            begin
              state <= arbIdle;
              ptr <= nextPort(owner);
            end
          end
        end
        default:
        begin
          state <= arbIdle;
        end
      endcase
    end
  end

  always_comb
  begin
    grant = '0;
    if (state == arbBusy)
      grant[owner] = 1'b1;
  end

endmodule

/* rtl/inputPort.sv */
`timescale 1ns/100ps
`include "router_settings.svh"

module inputPort
  import routerPkg::*;
#(
  parameter int routerX = 0,
  parameter int routerY = 0
)
(
  input  logic       clk,
  input  logic       rst,
  input  logic       inValid,
  input  flitT       inFlit,
  input  logic [4:0] sent,
  output logic       creditOut,
  output logic [4:0] reqVec,
  output flitT       frontFlit,
  output lenT        frontLen,
  output logic       notEmpty
);

  localparam int PtrW = (`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1;
  localparam int HeadBit = `FLIT_W - 1;
  localparam int XHi = HeadBit - 1;
  localparam int YHi = XHi - `COORD_W;
  localparam int LenHi = YHi - `COORD_W;

  flitT mem [`FIFO_DEPTH];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  creditT count;
  logic pop;
  logic push;
  logic isHead;
  coordT destX;
  coordT destY;
  portT headRoute;
  portT routeReg;
  portT curRoute;

  assign notEmpty = (count != '0);
  assign pop = (|sent) && notEmpty;
  // upstream only sends on credit, so a full FIFO is never written
  assign push = inValid && ((count != creditT'(`FIFO_DEPTH)) || pop);

  assign frontFlit = mem[rdPtr];
  assign frontLen = frontFlit[LenHi -: `LEN_W];
  assign isHead = frontFlit[HeadBit];
  assign destX = frontFlit[XHi -: `COORD_W];
  assign destY = frontFlit[YHi -: `COORD_W];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wrPtr] <= inFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      creditOut <= 1'b0;
    end
    else
    begin
      if (push)
      begin
        wrPtr <= (wrPtr == PtrW'(`FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop)
      begin
        rdPtr <= (rdPtr == PtrW'(`FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      count <= count + creditT'(push) - creditT'(pop);
      // one credit back upstream per popped flit
      creditOut <= pop;
    end
  end

  // dimension ordered, X first
  always_comb
  begin
    if (destX > coordT'(routerX))
      headRoute = portEast;
    else if (destX < coordT'(routerX))
      headRoute = portWest;
    else if (destY > coordT'(routerY))
      headRoute = portNorth;
    else if (destY < coordT'(routerY))
      headRoute = portSouth;
    else
      headRoute = portLocal;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      routeReg <= portLocal;
    else if (notEmpty && isHead)
      routeReg <= headRoute;
  end

  // body flits follow the route of their head
  assign curRoute = isHead ? headRoute : routeReg;

  always_comb
  begin
    reqVec = '0;
    if (notEmpty)
      reqVec[curRoute] = 1'b1;
  end

endmodule

/* rtl/routerPkg.sv */
`include "router_settings.svh"

package routerPkg;

  typedef logic [`FLIT_W-1:0] flitT;

  typedef logic [`COORD_W-1:0] coordT;

  typedef logic [`LEN_W-1:0] lenT;

  // holds 0 up to FIFO_DEPTH
  typedef logic [$clog2(`FIFO_DEPTH+1)-1:0] creditT;

  // index of every per-port vector
  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portT;

  typedef enum logic {
    arbIdle,
    arbBusy
  } arbStateT;

endpackage

/* rtl/router_settings.svh */
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// entries per input FIFO, also the starting credits of every link
`define FIFO_DEPTH 4

// bits per mesh coordinate
`define COORD_W 3

// packet length field, counted in flits including the head
`define LEN_W 8

// head flit layout from the top down:
// head marker, dest X, dest Y, length, then payload
`define FLIT_W 32

`endif
